// File: tb.f
+incdir+common
common/mioc_map_pkg.sv
common/mioc_dram_pkg.sv
common/cpu_bus_if.sv
memory_map/memory_map_decode.sv
dram_cycle/dram_cycle_fsm.sv
rtl/mem_strobe_gen.sv
rtl/mioc_top.sv
tb/tb_mioc.sv

// File: Bender.yml
package:
  name: mioc

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/mioc_map_pkg.sv
      - common/mioc_dram_pkg.sv
      - common/cpu_bus_if.sv
      - memory_map/memory_map_decode.sv
      - dram_cycle/dram_cycle_fsm.sv
      - rtl/mem_strobe_gen.sv
      - rtl/mioc_top.sv

  - target: simulation
    include_dirs:
      - common
    files:
      - tb/tb_mioc.sv

// File: tb/tb_mioc.sv
`timescale 1ns/1ns
`include "mioc_macros.svh"

module tb_mioc;

   import mioc_map_pkg::*;
   import mioc_dram_pkg::*;

   localparam int N_ACCESS   = 95;                                     // accesses over all tests
   localparam int N_IO_WR    = 20;                                     // i/o writes over all tests
   localparam int MAX_CYCLES = 16 + 4 + N_ACCESS * 10 + N_IO_WR * 2;   // worst case per item
   localparam int TIMEOUT_NS = 2 * MAX_CYCLES * 4;                     // 4 ns clock with 2x margin

   logic      b_phi;
   logic      arst_n;
   cpu_addr_t ba;
   map_data_t bd;
   logic      mreq_n, iorq_n, wr_n, rfsh_n;
   logic      ras_n, mux, cas1_n, cas2_n;
   logic      bootromcs_n, auxromcs_n, en245_n, ra7;

   logic [31:0] lfsr = 32'h59ec;   // stimulus seed
   map_data_t   m_map;              // model copy of the map register
   dram_state_e m_state;            // model cycle phase
   int          err_count   = 0;
   int          check_count = 0;
   int          test_errs;

   mioc_top u_mioc_top (
      .b_phi       (b_phi),
      .arst_n      (arst_n),
      .ba          (ba),
      .bd          (bd),
      .mreq_n      (mreq_n),
      .iorq_n      (iorq_n),
      .wr_n        (wr_n),
      .rfsh_n      (rfsh_n),
      .ras_n       (ras_n),
      .mux         (mux),
      .cas1_n      (cas1_n),
      .cas2_n      (cas2_n),
      .bootromcs_n (bootromcs_n),
      .auxromcs_n  (auxromcs_n),
      .en245_n     (en245_n),
      .ra7         (ra7)
   );

   initial b_phi = 1'b0;
   always #2 b_phi = ~b_phi;   // 4 ns period

   // galois lfsr stepped once per bit taken
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] val;
      val = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
         val  = {val[30:0], lfsr[0]};
      end
      return val;
   endfunction

   // device expected from the map table
   function automatic mem_target_e expect_target(input map_data_t map, input cpu_addr_t addr);
      mem_target_e t;
      if (addr[15] == 1'b0) begin
         case (map[1:0])
            2'd0:    t = TGT_BOOT_ROM;
            2'd1:    t = TGT_RAM1;
            2'd2:    t = TGT_RAM2;
            default: t = TGT_ONBOARD;
         endcase
      end else begin
         case (map[3:2])
            2'd0:    t = TGT_RAM1;
            2'd1:    t = TGT_RAM2;
            2'd2:    t = TGT_AUX_ROM;
            default: t = TGT_ONBOARD;
         endcase
      end
      return t;
   endfunction

   task automatic check_bit(input string what, input logic got, input logic exp);
      check_count++;
      assert (got === exp) else begin
         $display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
         err_count++;
      end
   endtask

   // reference model of the map write and cycle timing
   always @(posedge b_phi or negedge arst_n) begin
      if (!arst_n) begin
         m_map   = '0;
         m_state = ST_IDLE;
      end else begin
         if (!iorq_n && !wr_n && (ba[7:6] == `MIOC_MAP_PORT))
            m_map = bd;   // map port strobe
         case (m_state)
            ST_IDLE: if (!mreq_n) m_state = rfsh_n ? ST_ROW : ST_REFRESH;
            ST_ROW:  m_state = ST_COL;   // row lasts one cycle
            default: if (mreq_n) m_state = ST_IDLE;
         endcase
      end
   end

   // compare every output shortly after each rising edge
   always @(posedge b_phi) begin
      mem_target_e t;
      logic        col, acc;
      #1;
      t   = expect_target(m_map, ba);
      col = (m_state == ST_COL);
      acc = (m_state == ST_ROW) || col;
      check_bit("ras_n", ras_n, m_state == ST_IDLE);
      check_bit("mux", mux, col);
      check_bit("cas1_n", cas1_n, !(col && t == TGT_RAM1));
      check_bit("cas2_n", cas2_n, !(col && t == TGT_RAM2));
      check_bit("bootromcs_n", bootromcs_n, !(acc && t == TGT_BOOT_ROM));
      check_bit("auxromcs_n", auxromcs_n, !(acc && t == TGT_AUX_ROM));
      check_bit("en245_n", en245_n, !(acc && t == TGT_ONBOARD));
      check_bit("ra7", ra7, col ? ba[15] : ba[7]);
   end

   // starts and ends on a falling edge
   task automatic io_write(input cpu_addr_t addr, input map_data_t data, input logic wr);
      ba     = addr;
      bd     = data;
      iorq_n = 1'b0;
      wr_n   = wr;
      @(negedge b_phi);
      iorq_n = 1'b1;
      wr_n   = 1'b1;
      @(negedge b_phi);
   endtask

   task automatic mem_access(input cpu_addr_t addr, input int len, input logic refresh);
      int waited;
      waited = 0;
      ba     = addr;
      mreq_n = 1'b0;
      rfsh_n = !refresh;
      for (int i = 0; i < len; i++) begin
         @(negedge b_phi);
         if (refresh) begin   // ras only so nothing else may move
            check_bit("mux in refresh", mux, 1'b0);
            check_bit("cas1_n in refresh", cas1_n, 1'b1);
            check_bit("cas2_n in refresh", cas2_n, 1'b1);
            check_bit("bootromcs_n in refresh", bootromcs_n, 1'b1);
            check_bit("auxromcs_n in refresh", auxromcs_n, 1'b1);
            check_bit("en245_n in refresh", en245_n, 1'b1);
         end else if (i == 0) begin
            check_bit("ras_n after first edge", ras_n, 1'b0);
            check_bit("mux after first edge", mux, 1'b0);
         end else if (i == 1) begin
            check_bit("mux after second edge", mux, 1'b1);
         end
      end
      mreq_n = 1'b1;
      rfsh_n = 1'b1;
      @(negedge b_phi);
      while (ras_n !== 1'b1 && waited < 4) begin   // address held until the cycle ends
         @(negedge b_phi);
         waited++;
      end
      assert (ras_n === 1'b1) else begin
         $display("ras_n stayed low after the request ended, at %0t ns", $time);
         err_count++;
      end
   endtask

   task automatic report_test(input int num, input string name);
      $display("test %0d %s done, %0d errors", num, name, err_count - test_errs);
      test_errs = err_count;
   endtask

   initial begin
      cpu_addr_t a;
      logic [1:0] port;
      ba        = '0;
      bd        = '0;
      mreq_n    = 1'b1;
      iorq_n    = 1'b1;
      wr_n      = 1'b1;
      rfsh_n    = 1'b1;
      arst_n    = 1'b0;
      test_errs = 0;
      repeat (16) @(posedge b_phi);
      @(negedge b_phi);
      arst_n = 1'b1;
      @(negedge b_phi);

      // test 1 reset values and boot rom on a lower read
      check_bit("ras_n after reset", ras_n, 1'b1);
      check_bit("mux after reset", mux, 1'b0);
      check_bit("cas1_n after reset", cas1_n, 1'b1);
      check_bit("cas2_n after reset", cas2_n, 1'b1);
      check_bit("bootromcs_n after reset", bootromcs_n, 1'b1);
      check_bit("auxromcs_n after reset", auxromcs_n, 1'b1);
      check_bit("en245_n after reset", en245_n, 1'b1);
      ba     = 16'(take_bits(16)) & 16'h7fff;
      mreq_n = 1'b0;
      @(negedge b_phi);
      check_bit("bootromcs_n on lower read", bootromcs_n, 1'b0);
      mreq_n = 1'b1;   // one column cycle before idle
      repeat (2) @(negedge b_phi);
      check_bit("ras_n after lower read", ras_n, 1'b1);
      report_test(1, "reset and boot rom");

      // test 2 map writes followed by accesses
      for (int w = 0; w < 8; w++) begin
         a = {8'(take_bits(8)), 2'b01, 6'(take_bits(6))};   // addr[7:6] on the map port
         io_write(a, 4'(take_bits(4)), 1'b0);
         for (int k = 0; k < 4; k++)
            mem_access(16'(take_bits(16)), 1 + take_bits(3) % 3, 1'b0);
      end
      report_test(2, "map writes and decode");

      // test 3 other ports and reads leave the map alone
      for (int w = 0; w < 12; w++) begin
         if (take_bits(1)) begin
            port = 2'(take_bits(2));
            if (port == `MIOC_MAP_PORT)
               port = 2'b11;
            io_write({8'(take_bits(8)), port, 6'(take_bits(6))}, 4'(take_bits(4)), 1'b0);
         end else begin
            io_write({8'(take_bits(8)), 2'b01, 6'(take_bits(6))}, 4'(take_bits(4)), 1'b1);
         end
         mem_access(16'(take_bits(16)) & 16'h7fff, 2, 1'b0);
         mem_access(16'(take_bits(16)) | 16'h8000, 2, 1'b0);
      end
      report_test(3, "foreign i/o writes");

      // test 4 request lengths 1 to 5
      for (int k = 0; k < 16; k++)
         mem_access(16'(take_bits(16)), 1 + take_bits(3) % 5, 1'b0);
      report_test(4, "access timing");

      // test 5 refresh cycles
      for (int k = 0; k < 10; k++)
         mem_access(16'(take_bits(16)), 1 + take_bits(3) % 4, 1'b1);
      report_test(5, "refresh");

      // test 6 ra7 row and column source
      for (int k = 0; k < 12; k++)
         mem_access(16'(take_bits(16)), 2 + take_bits(2) % 3, 1'b0);
      report_test(6, "ra7 mux");

      $display("tests run 6, checks %0d, errors %0d", check_count, err_count);
      if (err_count == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

   // watchdog
   initial begin
      #(TIMEOUT_NS);
      $display("timeout, the tests did not finish within %0d ns", TIMEOUT_NS);
      $display(">>> FAIL");
      $finish;
   end

endmodule

// File: rtl/mioc_top.sv
`timescale 1ns/1ns

module mioc_top (
   input  logic                    b_phi,         // z80 clock
   input  logic                    arst_n,
   input  mioc_map_pkg::cpu_addr_t ba,            // buffered address
   input  mioc_map_pkg::map_data_t bd,            // data nibble for map writes
   input  logic                    mreq_n,        // buffered memory request
   input  logic                    iorq_n,        // i/o request
   input  logic                    wr_n,          // buffered write
   input  logic                    rfsh_n,        // buffered refresh
   output logic                    ras_n,         // row strobe
   output logic                    mux,           // dram address mux
   output logic                    cas1_n,        // column strobe ram 1
   output logic                    cas2_n,        // column strobe ram 2
   output logic                    bootromcs_n,   // boot rom select
   output logic                    auxromcs_n,    // expansion rom select
   output logic                    en245_n,       // onboard decode buffer enable
   output logic                    ra7            // dram address msb
);

   import mioc_map_pkg::*;
   import mioc_dram_pkg::*;

   mem_target_e target;   // decoded device
   dram_state_e state;    // cycle phase

   // pins onto the internal bus
   cpu_bus_if u_bus ();

   assign u_bus.addr   = ba;
   assign u_bus.data   = bd;
   assign u_bus.mreq_n = mreq_n;
   assign u_bus.iorq_n = iorq_n;
   assign u_bus.wr_n   = wr_n;
   assign u_bus.rfsh_n = rfsh_n;

   // map register and device decode
   memory_map_decode u_memory_map_decode (
      .b_phi  (b_phi),
      .arst_n (arst_n),
      .bus    (u_bus.map_mp),
      .target (target)
   );

   // row, column and refresh sequencing
   dram_cycle_fsm u_dram_cycle_fsm (
      .b_phi  (b_phi),
      .arst_n (arst_n),
      .bus    (u_bus.cycle_mp),
      .state  (state),
      .ras_n  (ras_n),
      .mux    (mux)
   );

   // chip selects, cas and ra7
   mem_strobe_gen u_mem_strobe_gen (
      .state       (state),
      .target      (target),
      .addr        (u_bus.addr),
      .cas1_n      (cas1_n),
      .cas2_n      (cas2_n),
      .bootromcs_n (bootromcs_n),
      .auxromcs_n  (auxromcs_n),
      .en245_n     (en245_n),
      .ra7         (ra7)
   );

endmodule

// File: rtl/mem_strobe_gen.sv
`timescale 1ns/1ns
`include "mioc_macros.svh"

module mem_strobe_gen (
   input  mioc_dram_pkg::dram_state_e state,         // cycle phase
   input  mioc_map_pkg::mem_target_e  target,        // decoded device
   input  mioc_map_pkg::cpu_addr_t    addr,          // live cpu address
   output logic                       cas1_n,        // column strobe bank 1
   output logic                       cas2_n,        // column strobe bank 2
   output logic                       bootromcs_n,
   output logic                       auxromcs_n,
   output logic                       en245_n,       // onboard decode enable
   output logic                       ra7            // muxed dram address msb
);

   import mioc_map_pkg::*;
   import mioc_dram_pkg::*;

   logic col_phase;   // column half of an access
   logic acc_phase;   // row or column, never refresh

   assign col_phase = (state == ST_COL);
   assign acc_phase = (state == ST_ROW) || col_phase;

   // cas only in the column phase
   assign cas1_n = !(col_phase && (target == TGT_RAM1));
   assign cas2_n = !(col_phase && (target == TGT_RAM2));

   // rom and onboard selects cover the whole access
   assign bootromcs_n = !(acc_phase && (target == TGT_BOOT_ROM));
   assign auxromcs_n  = !(acc_phase && (target == TGT_AUX_ROM));
   assign en245_n     = !(acc_phase && (target == TGT_ONBOARD));

   // a7 for row address, a15 for column
   assign ra7 = col_phase ? addr[`MIOC_RA7_COL] : addr[`MIOC_RA7_ROW];

endmodule

// File: dram_cycle/dram_cycle_fsm.sv
`timescale 1ns/1ns

module dram_cycle_fsm (
   input  logic                      b_phi,    // z80 clock
   input  logic                      arst_n,
   cpu_bus_if.cycle_mp               bus,
   output mioc_dram_pkg::dram_state_e state,   // current cycle phase
   output logic                      ras_n,    // row strobe, registered
   output logic                      mux       // row/column address select
);

   import mioc_dram_pkg::*;

   dram_state_e state_nxt;

   // next phase from mreq and rfsh
   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE: begin
            if (!bus.mreq_n) begin
               state_nxt = bus.rfsh_n ? ST_ROW : ST_REFRESH;   // refresh is ras only
            end
         end
         ST_ROW: begin
            state_nxt = ST_COL;   // one row cycle then column
         end
         ST_COL, ST_REFRESH: begin
            if (bus.mreq_n) begin
               state_nxt = ST_IDLE;   // request gone
            end
         end
         default: begin
            state_nxt = ST_IDLE;
         end
      endcase
   end

   // state and strobes share one edge
   // ras and mux come straight off flops so the dram sees clean edges
   always_ff @(posedge b_phi or negedge arst_n) begin
      if (!arst_n) begin
         state <= ST_IDLE;
         ras_n <= 1'b1;
         mux   <= 1'b0;
      end else begin
         state <= state_nxt;
         ras_n <= (state_nxt == ST_IDLE);   // low through row, col and refresh
         mux   <= (state_nxt == ST_COL);    // column address only in ST_COL
      end
   end

endmodule

// File: memory_map/memory_map_decode.sv
`timescale 1ns/1ns
`include "mioc_macros.svh"

module memory_map_decode (
   input  logic                      b_phi,    // z80 clock
   input  logic                      arst_n,
   cpu_bus_if.map_mp                 bus,
   output mioc_map_pkg::mem_target_e target    // device for the live address
);

   import mioc_map_pkg::*;

   map_reg_t map_q;       // current memory map
   logic     map_wr;      // i/o write to the map port this cycle
   logic     upper_sel;   // access falls in the upper 32k

   // port decode on addr[7:6], qualified by iorq and write
   assign map_wr = !bus.iorq_n && !bus.wr_n &&
                   (bus.addr[`MIOC_PORT_HI:`MIOC_PORT_LO] == `MIOC_MAP_PORT);

   assign upper_sel = bus.addr[`MIOC_BANK_BIT];

   // map register
   always_ff @(posedge b_phi or negedge arst_n) begin
      if (!arst_n) begin
         map_q <= map_reg_t'('0);   // boot rom low, ram1 high
      end else if (map_wr) begin
         map_q <= map_reg_t'(bus.data);   // bits 1:0 lower, 3:2 upper
      end
   end

   // address to device decode
   // new map takes effect right after the writing edge
   always_comb begin
      target = TGT_BOOT_ROM;
      if (!upper_sel) begin   // 0000-7fff
         case (map_q.lower)
            LOW_BOOT_ROM: target = TGT_BOOT_ROM;
            LOW_RAM1:     target = TGT_RAM1;
            LOW_RAM2:     target = TGT_RAM2;
            LOW_ONBOARD:  target = TGT_ONBOARD;   // handed to the cartridge decode
            default:      target = TGT_BOOT_ROM;
         endcase
      end else begin   // 8000-ffff
         case (map_q.upper)
            UP_RAM1:    target = TGT_RAM1;
            UP_RAM2:    target = TGT_RAM2;
            UP_AUX_ROM: target = TGT_AUX_ROM;   // expansion rom slot
            UP_ONBOARD: target = TGT_ONBOARD;
            default:    target = TGT_RAM1;
         endcase
      end
   end

endmodule

// File: common/cpu_bus_if.sv
`timescale 1ns/1ns

// buffered z80 bus as seen behind the input pads
interface cpu_bus_if;

   import mioc_map_pkg::*;

   cpu_addr_t addr;     // ba lines
   map_data_t data;     // low nibble of bd
   logic      mreq_n;   // memory request
   logic      iorq_n;   // i/o request
   logic      wr_n;     // buffered write
   logic      rfsh_n;   // refresh qualifier

   // map register writes and address decode
   modport map_mp (
      input addr,
      input data,
      input iorq_n,
      input wr_n
   );

   // dram cycle sequencing
   modport cycle_mp (
      input mreq_n,
      input rfsh_n
   );

endinterface

// File: common/mioc_dram_pkg.sv
`include "mioc_macros.svh"

package mioc_dram_pkg;

   // dram cycle phase
   //  ST_IDLE     no request seen
   //  ST_ROW      ras low, row address on the dram pins
   //  ST_COL      mux high, cas allowed for the selected bank
   //  ST_REFRESH  ras only cycle
   typedef enum logic [`MIOC_STATE_W-1:0] {
      ST_IDLE    = 2'd0,
      ST_ROW     = 2'd1,
      ST_COL     = 2'd2,
      ST_REFRESH = 2'd3
   } dram_state_e;

endpackage

// File: common/mioc_map_pkg.sv
`include "mioc_macros.svh"

package mioc_map_pkg;

   typedef logic [`MIOC_ADDR_W-1:0] cpu_addr_t;   // buffered cpu address
   typedef logic [`MIOC_MAP_W-1:0]  map_data_t;   // nibble written to the map port

   // lower 32k map
   typedef enum logic [`MIOC_FIELD_W-1:0] {
      LOW_BOOT_ROM = 2'd0,   // boot rom
      LOW_RAM1     = 2'd1,
      LOW_RAM2     = 2'd2,
      LOW_ONBOARD  = 2'd3    // cartridge side decode
   } lower_map_e;

   // upper 32k map
   typedef enum logic [`MIOC_FIELD_W-1:0] {
      UP_RAM1    = 2'd0,
      UP_RAM2    = 2'd1,
      UP_AUX_ROM = 2'd2,     // expansion rom slot
      UP_ONBOARD = 2'd3
   } upper_map_e;

   // map register as stored, upper field in bits 3:2
   typedef struct packed {
      upper_map_e upper;
      lower_map_e lower;
   } map_reg_t;

   // device picked for the current access
   typedef enum logic [`MIOC_TGT_W-1:0] {
      TGT_BOOT_ROM = 3'd0,
      TGT_RAM1     = 3'd1,
      TGT_RAM2     = 3'd2,
      TGT_AUX_ROM  = 3'd3,
      TGT_ONBOARD  = 3'd4
   } mem_target_e;

endpackage

// File: common/mioc_macros.svh
`ifndef MIOC_MACROS_SVH
`define MIOC_MACROS_SVH

// cpu bus widths
`define MIOC_ADDR_W     16    // z80 address bus
`define MIOC_MAP_W      4     // map register, one nibble off bd

// map register layout
`define MIOC_FIELD_W    2     // width of each map field

// encodings carried by the package enums
`define MIOC_TGT_W      3     // device select
`define MIOC_STATE_W    2     // dram cycle phase

// i/o port decode
`define MIOC_PORT_HI    7     // port select sits in address bits 7:6
`define MIOC_PORT_LO    6
`define MIOC_MAP_PORT   2'b01 // value of addr[7:6] for the map port

// address bits used by the memory side
`define MIOC_BANK_BIT   15    // splits lower and upper 32k
`define MIOC_RA7_ROW    7     // ra7 source during the row phase
`define MIOC_RA7_COL    15    // ra7 source during the column phase

`endif
